// ==== source/frog_geom_pkg.sv ====
`default_nettype none

package frog_geom_pkg;

    localparam int screen_w = 640;
    localparam int screen_h = 480;

    // Pixel coordinate wide enough for either screen axis
    typedef logic [9:0] coord_t;

    typedef enum logic [1:0] {
        up    = 2'b00,
        down  = 2'b01,
        left  = 2'b10,
        right = 2'b11
    } facing_t;

    // Home square at the bottom of the playfield, row 14
    localparam coord_t start_x = 10'd304;
    localparam coord_t start_y = 10'd448;

    localparam int goal_row = 0; // Top row ends the level

endpackage

`default_nettype wire

// ==== source/frog_game_pkg.sv ====
`default_nettype none

package frog_game_pkg;

    typedef enum logic [1:0] {
        menu    = 2'b00,
        playing = 2'b01,
        dead    = 2'b10,
        win     = 2'b11
    } game_state_t;

    localparam int n_lanes = 6;

    // Lane i sits on playfield row lane_row0 + i
    localparam int lane_row0 = 2;

    // Bit i set means lane i is water with a log, otherwise road with a car
    localparam logic [n_lanes-1:0] lane_is_river = 6'b000111;

    // Signed drift in pixels per frame tick
    typedef logic signed [9:0] speed_t;

    typedef speed_t [n_lanes-1:0] speed_arr_t;
    typedef frog_geom_pkg::coord_t [n_lanes-1:0] coord_arr_t;

endpackage

`default_nettype wire

// ==== source/lane_bus.sv ====
`default_nettype none

interface lane_bus;
    import frog_game_pkg::*;

    coord_arr_t obj_x;   // Left edge of the object in each lane
    speed_arr_t speed;   // Speeds latched while in the menu
    logic       riding;  // Frog stands on a log
    speed_t     ride_dx; // Speed of the log being ridden

    modport traffic (
        output obj_x,
        output speed
    );

    // Hazard side of the bus
    modport check (
        input  obj_x,
        input  speed,
        output riding,
        output ride_dx
    );

    modport rider (
        input riding,
        input ride_dx
    );

endinterface

`default_nettype wire

// ==== source/frog_mover.sv ====
`default_nettype none

module frog_mover #(
    parameter int block_size = 32,
    parameter int frog_size  = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  frog_game_pkg::game_state_t state,
    input  logic                       btn_up,
    input  logic                       btn_down,
    input  logic                       btn_left,
    input  logic                       btn_right,
    input  logic                       frame_tick,
    input  logic                       collision,
    input  logic                       reached_end,
    lane_bus.rider                     ride,
    output frog_geom_pkg::coord_t      frog_x,
    output frog_geom_pkg::coord_t      frog_y,
    output frog_geom_pkg::facing_t     facing
);
    import frog_geom_pkg::*;
    import frog_game_pkg::*;

    localparam int x_max = screen_w - frog_size; // Rightmost legal left edge

    coord_t  step_x;
    coord_t  step_y;
    facing_t step_facing;
    int      drift_x;
    coord_t  next_x;

    // One block step at most, the first pressed button wins even if refused
    always_comb begin
        step_x      = frog_x;
        step_y      = frog_y;
        step_facing = facing;
        if (btn_up) begin
            if (int'(frog_y) >= block_size) begin
                step_y      = coord_t'(int'(frog_y) - block_size);
                step_facing = up;
            end
        end else if (btn_down) begin
            if (int'(frog_y) + frog_size + block_size <= screen_h) begin
                step_y      = coord_t'(int'(frog_y) + block_size);
                step_facing = down;
            end
        end else if (btn_left) begin
            if (int'(frog_x) >= block_size) begin
                step_x      = coord_t'(int'(frog_x) - block_size);
                step_facing = left;
            end
        end else if (btn_right) begin
            if (int'(frog_x) + frog_size + block_size <= screen_w) begin
                step_x      = coord_t'(int'(frog_x) + block_size);
                step_facing = right;
            end
        end
    end

    // Log drift stacks on top of a step taken in the same cycle
    always_comb begin
        drift_x = int'(step_x);
        if (frame_tick && ride.riding) begin
            drift_x = drift_x + int'(ride.ride_dx);
        end

        if (drift_x < 0) begin
            next_x = '0;
        end else if (drift_x > x_max) begin
            next_x = coord_t'(x_max); // A log can push the frog into the edge
        end else begin
            next_x = coord_t'(drift_x);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || collision || reached_end) begin
            frog_x <= start_x;
            frog_y <= start_y;
            facing <= up;
        end else if (state == playing) begin
            frog_x <= next_x;
            frog_y <= step_y;
            facing <= step_facing;
        end
    end

    // The frog must stay fully on screen whatever the logs do
    assert property (@(posedge clk) disable iff (rst)
        int'(frog_x) + frog_size <= screen_w)
        else $error("frog_x %0d puts the frog past the right edge", frog_x);

endmodule

`default_nettype wire

// ==== source/lane_traffic.sv ====
`default_nettype none

module lane_traffic #(
    parameter int object_width = 96
) (
    input  logic                       clk,
    input  logic                       rst,
    input  frog_game_pkg::game_state_t state,
    input  logic                       frame_tick,
    input  frog_game_pkg::speed_arr_t  lane_speeds,
    lane_bus.traffic                   lanes
);
    import frog_geom_pkg::*;
    import frog_game_pkg::*;

    coord_arr_t obj_q;
    speed_arr_t speed_q;

    // Speed magnitude stays below the screen width, so one correction is enough
    function automatic coord_t wrap_step(input coord_t x, input speed_t v);
        int sum;
        sum = int'(x) + int'(v);
        if (sum < 0) begin
            sum = sum + screen_w;
        end else if (sum >= screen_w) begin
            sum = sum - screen_w;
        end
        return coord_t'(sum);
    endfunction

    // Objects start spread out one object width apart
    function automatic coord_t home_x(input int lane);
        return coord_t'((lane * object_width) % screen_w);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < n_lanes; i++) begin
                obj_q[i]   <= home_x(i);
                speed_q[i] <= '0;
            end
        end else if (state == menu) begin
            for (int i = 0; i < n_lanes; i++) begin
                obj_q[i]   <= home_x(i);
                speed_q[i] <= lane_speeds[i]; // Held for the whole round
            end
        end else if (state == playing && frame_tick) begin
            for (int i = 0; i < n_lanes; i++) begin
                obj_q[i] <= wrap_step(obj_q[i], speed_q[i]);
            end
        end
    end

    assign lanes.obj_x = obj_q;
    assign lanes.speed = speed_q;

    for (genvar i = 0; i < n_lanes; i++) begin : g_obj_range
        assert property (@(posedge clk) disable iff (rst) int'(obj_q[i]) < screen_w)
            else $error("lane %0d object at x=%0d is off the playfield", i, obj_q[i]);
    end

endmodule

`default_nettype wire

// ==== source/hazard_check.sv ====
`default_nettype none

module hazard_check #(
    parameter int block_size   = 32,
    parameter int frog_size    = 32,
    parameter int object_width = 96
) (
    input  frog_geom_pkg::coord_t frog_x,
    input  frog_geom_pkg::coord_t frog_y,
    lane_bus.check                lanes,
    output logic                  collision,
    output logic                  reached_end
);
    import frog_geom_pkg::*;
    import frog_game_pkg::*;

    int     row;
    int     lane;
    logic   in_lane;
    logic   is_river;
    coord_t obj;
    logic   overlap;
    logic   riding;

    // Distance from b forward to a around the wrapped playfield
    function automatic int gap(input coord_t a, input coord_t b);
        int d;
        d = int'(a) - int'(b);
        if (d < 0) begin
            d = d + screen_w;
        end
        return d;
    endfunction

    always_comb begin
        row      = int'(frog_y) / block_size;
        in_lane  = (row >= lane_row0) && (row < lane_row0 + n_lanes);
        lane     = in_lane ? row - lane_row0 : 0;
        obj      = lanes.obj_x[lane];
        is_river = lane_is_river[lane];
        // Objects wrap around the edge, so overlap is tested both ways
        overlap  = (gap(frog_x, obj) < object_width) || (gap(obj, frog_x) < frog_size);
    end

    assign collision = in_lane && (is_river ? !overlap : overlap);
    assign riding    = in_lane && is_river && overlap;

    assign lanes.riding  = riding;
    assign lanes.ride_dx = riding ? lanes.speed[lane] : speed_t'(0);

    assign reached_end = (int'(frog_y) == goal_row * block_size);

endmodule

`default_nettype wire

// ==== source/game_fsm.sv ====
`default_nettype none

module game_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       collision,
    input  logic                       reached_end,
    output frog_game_pkg::game_state_t state
);
    import frog_game_pkg::*;

    game_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            menu: begin
                if (start) state_next = playing;
            end
            playing: begin
                if (collision) begin
                    state_next = dead;
                end else if (reached_end) begin
                    state_next = win;
                end
            end
            dead, win: begin
                if (start) state_next = menu; // Back to the menu for new speeds
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= menu;
        end else begin
            state <= state_next;
        end
    end

    // Death only happens during play
    assert property (@(posedge clk) disable iff (rst)
        (state == dead && $past(state) != dead) |-> $past(state) == playing)
        else $error("dead entered from state %s", $past(state));

endmodule

`default_nettype wire

// ==== source/frogger_core.sv ====
`default_nettype none

module frogger_core #(
    parameter int block_size   = 32,
    parameter int frog_size    = 32,
    parameter int object_width = 96
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       btn_up,
    input  logic                       btn_down,
    input  logic                       btn_left,
    input  logic                       btn_right,
    input  logic                       frame_tick,
    input  frog_game_pkg::speed_arr_t  lane_speeds,
    output frog_geom_pkg::coord_t      frog_x,
    output frog_geom_pkg::coord_t      frog_y,
    output frog_geom_pkg::facing_t     facing,
    output frog_game_pkg::game_state_t game_state,
    output frog_game_pkg::coord_arr_t  lane_obj_x
);
    logic collision;
    logic reached_end;

    lane_bus lanes ();

    frog_mover #(
        .block_size (block_size),
        .frog_size  (frog_size)
    ) i_frog_mover (
        .clk         (clk),
        .rst         (rst),
        .state       (game_state),
        .btn_up      (btn_up),
        .btn_down    (btn_down),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .frame_tick  (frame_tick),
        .collision   (collision),
        .reached_end (reached_end),
        .ride        (lanes.rider),
        .frog_x      (frog_x),
        .frog_y      (frog_y),
        .facing      (facing)
    );

    lane_traffic #(
        .object_width (object_width)
    ) i_lane_traffic (
        .clk         (clk),
        .rst         (rst),
        .state       (game_state),
        .frame_tick  (frame_tick),
        .lane_speeds (lane_speeds),
        .lanes       (lanes.traffic)
    );

    hazard_check #(
        .block_size   (block_size),
        .frog_size    (frog_size),
        .object_width (object_width)
    ) i_hazard_check (
        .frog_x      (frog_x),
        .frog_y      (frog_y),
        .lanes       (lanes.check),
        .collision   (collision),
        .reached_end (reached_end)
    );

    game_fsm i_game_fsm (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .collision   (collision),
        .reached_end (reached_end),
        .state       (game_state)
    );

    assign lane_obj_x = lanes.obj_x;

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0; // Released on an edge like every other input
    end

endmodule

`default_nettype wire

// ==== test/tb_frogger.sv ====
`default_nettype none

module tb_frogger;
    timeunit 1ns;
    timeprecision 100ps;

    import frog_geom_pkg::*;
    import frog_game_pkg::*;

    localparam int scr_w          = 640;
    localparam int scr_h          = 480;
    localparam int blk            = 32;
    localparam int frog_sz        = 32;
    localparam int obj_w          = 96;
    localparam int home_x         = 304;
    localparam int home_y         = 448;
    localparam int first_lane_row = 2;
    localparam int river_lanes    = 3; // Lanes below this index carry logs
    localparam int run_cycles     = 3000;
    localparam int wd_cycles      = run_cycles * 5 / 3;

    logic        clk;
    logic        rst;
    logic        start;
    logic        btn_up;
    logic        btn_down;
    logic        btn_left;
    logic        btn_right;
    logic        frame_tick;
    speed_arr_t  lane_speeds;
    coord_t      frog_x;
    coord_t      frog_y;
    facing_t     facing;
    game_state_t game_state;
    coord_arr_t  lane_obj_x;

    // Reference model of the game
    game_state_t m_state;
    facing_t     m_facing;
    int          m_x;
    int          m_y;
    int          m_obj [n_lanes];
    int          m_speed [n_lanes];
    int          m_lane;
    logic        m_hit;
    logic        m_ride;
    logic        m_goal;
    int          m_ride_dx;

    int          speed_pick [n_lanes];
    logic [15:0] lfsr_q = 16'd16;
    int          cycle;

    tb_clock #(.period_ns(20), .reset_cycles(10)) i_clock (.clk(clk), .rst(rst));

    frogger_core #(
        .block_size   (blk),
        .frog_size    (frog_sz),
        .object_width (obj_w)
    ) i_dut (.*);

    function automatic int mod_screen(input int v);
        return ((v % scr_w) + scr_w) % scr_w;
    endfunction

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic value_mismatch(input string name, input int expected, input int actual);
        $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        abort_run();
    endtask

    always_comb begin
        m_lane    = m_y / blk - first_lane_row;
        m_hit     = 1'b0;
        m_ride    = 1'b0;
        m_ride_dx = 0;
        if (m_lane >= 0 && m_lane < n_lanes) begin
            if (mod_screen(m_x - m_obj[m_lane]) < obj_w ||
                    mod_screen(m_obj[m_lane] - m_x) < frog_sz) begin
                m_hit     = (m_lane >= river_lanes); // Struck by the car
                m_ride    = (m_lane < river_lanes);
                m_ride_dx = m_speed[m_lane];
            end else begin
                m_hit = (m_lane < river_lanes);      // Fell in the water
            end
        end
        m_goal = (m_y == 0);
    end

    always @(posedge clk) begin : model_step
        int      nx;
        int      ny;
        facing_t nf;
        nx = m_x;
        ny = m_y;
        nf = m_facing;
        if (btn_up) begin
            if (m_y >= blk) begin
                ny = m_y - blk;
                nf = up;
            end
        end else if (btn_down) begin
            if (m_y + frog_sz + blk <= scr_h) begin
                ny = m_y + blk;
                nf = down;
            end
        end else if (btn_left) begin
            if (m_x >= blk) begin
                nx = m_x - blk;
                nf = left;
            end
        end else if (btn_right) begin
            if (m_x + frog_sz + blk <= scr_w) begin
                nx = m_x + blk;
                nf = right;
            end
        end
        if (frame_tick && m_ride) nx = nx + m_ride_dx;
        nx = (nx < 0) ? 0 : (nx > scr_w - frog_sz) ? scr_w - frog_sz : nx;

        if (rst || m_hit || m_goal) begin
            m_x      <= home_x;
            m_y      <= home_y;
            m_facing <= up;
        end else if (m_state == playing) begin
            m_x      <= nx;
            m_y      <= ny;
            m_facing <= nf;
        end

        if (rst) begin
            m_state <= menu;
        end else if (m_state == menu) begin
            m_state <= start ? playing : menu;
        end else if (m_state == playing) begin
            m_state <= m_hit ? dead : m_goal ? win : playing;
        end else if (start) begin
            m_state <= menu;
        end

        for (int i = 0; i < n_lanes; i++) begin
            if (rst || m_state == menu) begin
                m_obj[i]   <= mod_screen(i * obj_w);
                m_speed[i] <= rst ? 0 : int'($signed(lane_speeds[i]));
            end else if (m_state == playing && frame_tick) begin
                m_obj[i] <= mod_screen(m_obj[i] + m_speed[i]);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) game_state == m_state)
        else value_mismatch("game_state", int'($sampled(m_state)), int'($sampled(game_state)));
    assert property (@(posedge clk) disable iff (rst) frog_x == m_x)
        else value_mismatch("frog_x", $sampled(m_x), int'($sampled(frog_x)));
    assert property (@(posedge clk) disable iff (rst) frog_y == m_y)
        else value_mismatch("frog_y", $sampled(m_y), int'($sampled(frog_y)));
    assert property (@(posedge clk) disable iff (rst) facing == m_facing)
        else value_mismatch("facing", int'($sampled(m_facing)), int'($sampled(facing)));

    for (genvar i = 0; i < n_lanes; i++) begin : g_lane_check
        assert property (@(posedge clk) disable iff (rst) lane_obj_x[i] == m_obj[i])
            else value_mismatch($sformatf("lane_obj_x[%0d]", i), $sampled(m_obj[i]),
                                int'($sampled(lane_obj_x[i])));
    end

    // Bit 0 of btns is up, then down, left and right
    task automatic apply(input logic [3:0] btns, input logic ft, input logic st);
        @(posedge clk);
        btn_up     <= btns[0];
        btn_down   <= btns[1];
        btn_left   <= btns[2];
        btn_right  <= btns[3];
        frame_tick <= ft;
        start      <= st;
        for (int i = 0; i < n_lanes; i++) begin
            lane_speeds[i] <= speed_t'(speed_pick[i]);
        end
        cycle++;
    endtask

    task automatic press(input int dir, input int times);
        for (int k = 0; k < times; k++) begin
            apply(4'b0001 << dir, 1'b0, 1'b0);
            apply(4'b0000, 1'b0, 1'b0);
        end
    endtask

    // Ticks while dead or won and in the menu must change nothing
    task automatic finish_game();
        int r;
        for (int k = 0; k < 10; k++) begin
            take_bits(5, r);
            apply(r[3:0], r[4], k == 5);
        end
    endtask

    // Roads stand still, so the frog walks over them onto the log in lane 2
    task automatic cross_game(input int log_speed);
        int n;
        foreach (speed_pick[i]) speed_pick[i] = 0;
        speed_pick[2] = log_speed;
        apply(4'b0000, 1'b0, 1'b1);
        press(2, 4);
        press(0, 10);
        if (log_speed == 0) begin
            press(0, 1);
            press(2, 3);
            press(0, 3);
        end else begin
            n = 0;
            while (game_state == playing && n < 200) begin
                apply(4'b0000, 1'b1, 1'b0);
                apply(4'b0000, 1'b0, 1'b0);
                n++;
            end
        end
        finish_game();
    endtask

    task automatic random_game();
        int b;
        int busy;
        int ft;
        int n;
        for (int i = 0; i < n_lanes; i++) begin
            take_bits(3, b);
            take_bits(1, busy);
            speed_pick[i] = busy ? -(b + 1) : b + 1;
        end
        apply(4'b0000, 1'b0, 1'b1);
        n = 0;
        while ((game_state == playing || n < 2) && n < 400) begin
            take_bits(4, b);
            take_bits(1, busy);
            take_bits(2, ft);
            if (n >= 250) begin
                b = 1; // A long game ends with a dash for the goal
            end else if (busy == 0) begin
                b = 0;
            end
            apply(b[3:0], ft == 0, 1'b0);
            n++;
        end
        finish_game();
    endtask

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
        abort_run();
    end

    initial begin
        start       = 1'b0;
        btn_up      = 1'b0;
        btn_down    = 1'b0;
        btn_left    = 1'b0;
        btn_right   = 1'b0;
        frame_tick  = 1'b0;
        lane_speeds = '0;
        foreach (speed_pick[i]) speed_pick[i] = 0;
        cycle = 0;
        wait (rst == 1'b0);
        apply(4'b0000, 1'b0, 1'b0);
        cross_game(0);
        cross_game(7);
        cross_game(-5);
        while (cycle < run_cycles - 200) begin
            random_game();
        end
        apply(4'b0000, 1'b0, 1'b0);
        apply(4'b0000, 1'b0, 1'b0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/frog_geom_pkg.sv
source/frog_game_pkg.sv
source/lane_bus.sv
source/frog_mover.sv
source/lane_traffic.sv
source/hazard_check.sv
source/game_fsm.sv
source/frogger_core.sv
test/tb_clock.sv
test/tb_frogger.sv
